//--- src/mips_isa_pkg.sv
`default_nettype none

package mips_isa_pkg;

	typedef enum logic [5:0] {
		OP_RTYPE = 6'd0,
		OP_ADDI  = 6'd8,
		OP_ORI   = 6'd13
	} opcode_e;

	typedef enum logic [5:0] {
		F_ADD = 6'd32,
		F_SUB = 6'd34,
		F_AND = 6'd36,
		F_OR  = 6'd37,
		F_SLT = 6'd42
	} funct_e;

	// Software names of the 32 general purpose registers, numbered 0 to 31.
	typedef enum logic [4:0] {
		ZERO, AT, V0, V1, A0, A1, A2, A3,
		T0, T1, T2, T3, T4, T5, T6, T7,
		S0, S1, S2, S3, S4, S5, S6, S7,
		T8, T9, K0, K1, GP, SP, FP, RA
	} reg_name_e;

	typedef enum logic [2:0] {
		ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_SLT
	} alu_op_e;

endpackage

`default_nettype wire

//--- src/rf_bus_pkg.sv
`default_nettype none

package rf_bus_pkg;

	typedef enum logic {
		REQ_EXEC, REQ_HOST
	} requester_e;

	typedef enum logic [1:0] {
		ARB_IDLE, ARB_ACK, ARB_RELEASE
	} arb_state_e;

	typedef enum logic [2:0] {
		EX_IDLE, EX_READ, EX_READ_DONE, EX_WRITE, EX_WRITE_DONE, EX_ACK
	} exec_state_e;

endpackage

`default_nettype wire

//--- src/rf_bus_if.sv
`timescale 1ns/1ps
`default_nettype none

interface rf_bus_if;

	logic        req;
	logic        ack;
	logic        we;
	logic [4:0]  raddr1;
	logic [4:0]  raddr2;
	logic [4:0]  waddr;
	logic [31:0] wdata;
	logic [31:0] rdata1;
	logic [31:0] rdata2;

	modport requester (
		output req, we, raddr1, raddr2, waddr, wdata,
		input  ack, rdata1, rdata2
	);

	modport arbiter_side (
		input  req, we, raddr1, raddr2, waddr, wdata,
		output ack, rdata1, rdata2
	);

	modport regfile_side (
		input  we, raddr1, raddr2, waddr, wdata,
		output rdata1, rdata2
	);

endinterface

`default_nettype wire

//--- src/register_file.sv
`timescale 1ns/1ps
`default_nettype none

module register_file import mips_isa_pkg::*; (
	input  logic clk,
	input  logic rst,
	rf_bus_if.regfile_side bus
);

	logic [31:0] regs [32];

	// *******************************************************************
	// Write port
	// *******************************************************************

	always_ff @(posedge clk) begin
		if (!rst) begin
			for (int i = 0; i < 32; i++) begin
				regs[i] <= '0;
			end
		end else if (bus.we && bus.waddr != ZERO) begin
			regs[bus.waddr] <= bus.wdata; // Writes to $zero are dropped here.
		end
	end

	// *******************************************************************
	// Read ports
	// *******************************************************************

	// Reads are asynchronous, so a read in the write cycle sees the old value.
	assign bus.rdata1 = (bus.raddr1 == ZERO) ? '0 : regs[bus.raddr1];
	assign bus.rdata2 = (bus.raddr2 == ZERO) ? '0 : regs[bus.raddr2];

endmodule

`default_nettype wire

//--- src/rf_arbiter.sv
`timescale 1ns/1ps
`default_nettype none

module rf_arbiter import rf_bus_pkg::*; (
	input  logic clk,
	input  logic rst,
	rf_bus_if.arbiter_side exec_bus,
	rf_bus_if.arbiter_side host_bus,
	rf_bus_if.requester    rf_bus
);

	arb_state_e state;
	requester_e last_grant; // Also the live grant while in ARB_ACK.
	requester_e pick;
	logic       any_req;
	logic       sel_host;
	logic       grant_req;

	assign any_req = exec_bus.req | host_bus.req;

	always_comb begin
		if (exec_bus.req && host_bus.req) begin
			pick = (last_grant == REQ_EXEC) ? REQ_HOST : REQ_EXEC; // Round robin on a tie.
		end else if (host_bus.req) begin
			pick = REQ_HOST;
		end else begin
			pick = REQ_EXEC;
		end
	end

	assign sel_host  = (state == ARB_IDLE) ? (pick == REQ_HOST) : (last_grant == REQ_HOST);
	assign grant_req = (last_grant == REQ_HOST) ? host_bus.req : exec_bus.req;

	always_ff @(posedge clk) begin
		if (!rst) begin
			state      <= ARB_IDLE;
			last_grant <= REQ_HOST;
		end else begin
			case (state)
				ARB_IDLE: begin
					if (any_req) begin
						last_grant <= pick;
						state      <= ARB_ACK;
					end
				end
				ARB_ACK: begin
					if (!grant_req) begin
						state <= ARB_RELEASE;
					end
				end
				default: state <= ARB_IDLE; // One dead cycle after every release.
			endcase
		end
	end

	// The granted side's fields are steered onto the register file bus.
	assign rf_bus.req    = (state == ARB_IDLE && any_req) || state == ARB_ACK;
	assign rf_bus.raddr1 = sel_host ? host_bus.raddr1 : exec_bus.raddr1;
	assign rf_bus.raddr2 = sel_host ? host_bus.raddr2 : exec_bus.raddr2;
	assign rf_bus.waddr  = sel_host ? host_bus.waddr : exec_bus.waddr;
	assign rf_bus.wdata  = sel_host ? host_bus.wdata : exec_bus.wdata;
	assign rf_bus.we     = (state == ARB_IDLE) && any_req &&
		(sel_host ? host_bus.we : exec_bus.we); // Write lands on the ack-rise edge.

	assign exec_bus.ack    = (state == ARB_ACK) && (last_grant == REQ_EXEC);
	assign host_bus.ack    = (state == ARB_ACK) && (last_grant == REQ_HOST);
	assign exec_bus.rdata1 = exec_bus.ack ? rf_bus.rdata1 : '0;
	assign exec_bus.rdata2 = exec_bus.ack ? rf_bus.rdata2 : '0;
	assign host_bus.rdata1 = host_bus.ack ? rf_bus.rdata1 : '0;
	assign host_bus.rdata2 = host_bus.ack ? rf_bus.rdata2 : '0;

endmodule

`default_nettype wire

//--- src/instr_executor.sv
`timescale 1ns/1ps
`default_nettype none

module instr_executor import mips_isa_pkg::*, rf_bus_pkg::*; (
	input  logic        clk,
	input  logic        rst,
	input  logic        instr_req,
	input  logic [31:0] instr,
	output logic        instr_ack,
	output logic [31:0] result,
	output logic        illegal,
	rf_bus_if.requester bus
);

	exec_state_e state;
	logic [31:0] instr_q;
	alu_op_e     alu_op;
	logic        dec_illegal;
	logic        is_itype;
	logic        sign_ext;
	logic [31:0] imm_ext;
	logic [31:0] op_b;
	logic [31:0] alu_out;

	// *******************************************************************
	// Decode
	// *******************************************************************

	always_comb begin
		alu_op      = ALU_ADD;
		dec_illegal = 1'b0;
		is_itype    = 1'b0;
		sign_ext    = 1'b0;
		case (opcode_e'(instr_q[31:26]))
			OP_RTYPE: begin
				case (funct_e'(instr_q[5:0]))
					F_ADD:   alu_op = ALU_ADD;
					F_SUB:   alu_op = ALU_SUB;
					F_AND:   alu_op = ALU_AND;
					F_OR:    alu_op = ALU_OR;
					F_SLT:   alu_op = ALU_SLT;
					default: dec_illegal = 1'b1;
				endcase
			end
			OP_ADDI: begin
				is_itype = 1'b1;
				sign_ext = 1'b1;
			end
			OP_ORI: begin
				is_itype = 1'b1;
				alu_op   = ALU_OR;
			end
			default: dec_illegal = 1'b1;
		endcase
	end

	assign imm_ext = sign_ext ? {{16{instr_q[15]}}, instr_q[15:0]} : {16'b0, instr_q[15:0]};
	assign op_b    = is_itype ? imm_ext : bus.rdata2;

	// Operands come straight off the bus while the read ack is high.
	always_comb begin
		case (alu_op)
			ALU_ADD: alu_out = bus.rdata1 + op_b;
			ALU_SUB: alu_out = bus.rdata1 - op_b;
			ALU_AND: alu_out = bus.rdata1 & op_b;
			ALU_OR:  alu_out = bus.rdata1 | op_b;
			ALU_SLT: alu_out = {31'b0, $signed(bus.rdata1) < $signed(op_b)};
			default: alu_out = '0;
		endcase
	end

	// *******************************************************************
	// Sequencing
	// *******************************************************************

	always_ff @(posedge clk) begin
		if (!rst) begin
			state   <= EX_IDLE;
			illegal <= 1'b0;
		end else begin
			case (state)
				EX_IDLE: begin
					if (instr_req) begin
						illegal <= 1'b0;
						state   <= EX_READ;
					end
				end
				EX_READ: begin
					if (bus.ack) begin
						illegal <= dec_illegal;
						state   <= EX_READ_DONE;
					end
				end
				EX_READ_DONE: begin
					if (!bus.ack) begin
						state <= illegal ? EX_ACK : EX_WRITE; // No write-back when illegal.
					end
				end
				EX_WRITE: begin
					if (bus.ack) begin
						state <= EX_WRITE_DONE;
					end
				end
				EX_WRITE_DONE: begin
					if (!bus.ack) begin
						state <= EX_ACK;
					end
				end
				EX_ACK: begin
					if (!instr_req) begin
						state <= EX_IDLE;
					end
				end
				default: state <= EX_IDLE;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (state == EX_IDLE && instr_req) begin
			instr_q <= instr;
		end
		if (state == EX_READ && bus.ack) begin
			result <= dec_illegal ? '0 : alu_out;
		end
	end

	assign instr_ack  = (state == EX_ACK);
	assign bus.req    = (state == EX_READ) || (state == EX_WRITE);
	assign bus.we     = (state == EX_WRITE);
	assign bus.raddr1 = instr_q[25:21]; // rs
	assign bus.raddr2 = instr_q[20:16]; // rt
	assign bus.waddr  = is_itype ? instr_q[20:16] : instr_q[15:11];
	assign bus.wdata  = result;

endmodule

`default_nettype wire

//--- src/host_reg_port.sv
`timescale 1ns/1ps
`default_nettype none

module host_reg_port (
	input  logic        clk,
	input  logic        rst,
	input  logic        host_req,
	input  logic        host_we,
	input  logic [4:0]  host_addr,
	input  logic [31:0] host_wdata,
	output logic        host_ack,
	output logic [31:0] host_rdata,
	rf_bus_if.requester bus
);

	typedef enum logic [1:0] {
		HP_IDLE, HP_BUS, HP_ACK
	} host_state_e;

	host_state_e state;
	logic        we_q;
	logic [4:0]  addr_q;
	logic [31:0] wdata_q;

	always_ff @(posedge clk) begin
		if (!rst) begin
			state <= HP_IDLE;
		end else begin
			case (state)
				HP_IDLE: begin
					if (host_req) begin
						state <= HP_BUS;
					end
				end
				HP_BUS: begin
					if (bus.ack) begin
						state <= HP_ACK;
					end
				end
				HP_ACK: begin
					if (!host_req) begin
						state <= HP_IDLE;
					end
				end
				default: state <= HP_IDLE;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (state == HP_IDLE && host_req) begin
			we_q    <= host_we;
			addr_q  <= host_addr;
			wdata_q <= host_wdata;
		end
		if (state == HP_BUS && bus.ack) begin
			host_rdata <= bus.rdata1; // Held until the next transaction.
		end
	end

	assign host_ack   = (state == HP_ACK);
	assign bus.req    = (state == HP_BUS);
	assign bus.we     = we_q;
	assign bus.raddr1 = addr_q;
	assign bus.raddr2 = addr_q;
	assign bus.waddr  = addr_q;
	assign bus.wdata  = wdata_q;

endmodule

`default_nettype wire

//--- src/mips_exec_top.sv
`timescale 1ns/1ps
`default_nettype none

module mips_exec_top (
	input  logic        clk,
	input  logic        rst,
	input  logic        instr_req,
	input  logic [31:0] instr,
	output logic        instr_ack,
	output logic [31:0] result,
	output logic        illegal,
	input  logic        host_req,
	input  logic        host_we,
	input  logic [4:0]  host_addr,
	input  logic [31:0] host_wdata,
	output logic        host_ack,
	output logic [31:0] host_rdata
);

	rf_bus_if exec_bus (); // REQ_EXEC side of the arbiter.
	rf_bus_if host_bus (); // REQ_HOST side of the arbiter.
	rf_bus_if rf_bus ();

	instr_executor u_exec (
		.clk       (clk),
		.rst       (rst),
		.instr_req (instr_req),
		.instr     (instr),
		.instr_ack (instr_ack),
		.result    (result),
		.illegal   (illegal),
		.bus       (exec_bus)
	);

	host_reg_port u_host (
		.clk        (clk),
		.rst        (rst),
		.host_req   (host_req),
		.host_we    (host_we),
		.host_addr  (host_addr),
		.host_wdata (host_wdata),
		.host_ack   (host_ack),
		.host_rdata (host_rdata),
		.bus        (host_bus)
	);

	rf_arbiter u_arb (
		.clk      (clk),
		.rst      (rst),
		.exec_bus (exec_bus),
		.host_bus (host_bus),
		.rf_bus   (rf_bus)
	);

	register_file u_rf (
		.clk (clk),
		.rst (rst),
		.bus (rf_bus)
	);

endmodule

`default_nettype wire

//--- verification/rf_checker.sv
`timescale 1ns/1ps
`default_nettype none

module rf_checker (
	input  logic        clk,
	input  logic        rst,
	input  logic        instr_ack,
	input  logic [31:0] result,
	input  logic        illegal,
	input  logic        host_ack,
	input  logic [31:0] host_rdata,
	input  logic [31:0] exp_result,
	input  logic        exp_illegal,
	input  logic        host_is_read,
	input  logic [31:0] exp_host_rdata,
	output int          pass_cnt,
	output int          fail_cnt
);

	logic instr_ack_q;
	logic host_ack_q;
	int   n_pass = 0;
	int   n_fail = 0;

	assign pass_cnt = n_pass;
	assign fail_cnt = n_fail;

	task automatic check_instr();
		logic ok;
		ok = 1'b1;
		if (illegal !== exp_illegal) begin
			$display("FAIL t=%0t illegal expected %0b got %0b", $time, exp_illegal, illegal);
			ok = 1'b0;
		end
		if (!exp_illegal && result !== exp_result) begin
			$display("FAIL t=%0t result expected %08h got %08h", $time, exp_result, result);
			ok = 1'b0;
		end
		if (ok) begin
			n_pass = n_pass + 1;
			$display("PASS t=%0t instruction result %08h illegal %0b", $time, result, illegal);
		end else begin
			n_fail = n_fail + 1;
		end
	endtask

	task automatic check_host();
		if (!host_is_read) begin
			$display("DONE t=%0t host write", $time);
		end else if (host_rdata !== exp_host_rdata) begin
			n_fail = n_fail + 1;
			$display("FAIL t=%0t host_rdata expected %08h got %08h", $time, exp_host_rdata,
				host_rdata);
		end else begin
			n_pass = n_pass + 1;
			$display("PASS t=%0t host read %08h", $time, host_rdata);
		end
	endtask

	// Both acks are sampled at the clock edge, so results are checked once per rise.
	always @(posedge clk) begin
		if (!rst) begin
			instr_ack_q <= 1'b0;
			host_ack_q  <= 1'b0;
		end else begin
			instr_ack_q <= instr_ack;
			host_ack_q  <= host_ack;
			if (instr_ack === 1'b1 && instr_ack_q === 1'b0) begin
				check_instr();
			end
			if (host_ack === 1'b1 && host_ack_q === 1'b0) begin
				check_host();
			end
		end
	end

endmodule

`default_nettype wire

//--- verification/tb_mips_exec.sv
`timescale 1ns/1ps
`default_nettype none

module tb_mips_exec import mips_isa_pkg::*; ();

	logic        clk;
	logic        rst;
	logic        instr_req;
	logic [31:0] instr;
	logic        instr_ack;
	logic [31:0] result;
	logic        illegal;
	logic        host_req;
	logic        host_we;
	logic [4:0]  host_addr;
	logic [31:0] host_wdata;
	logic        host_ack;
	logic [31:0] host_rdata;
	logic [31:0] exp_result;
	logic        exp_illegal;
	logic        host_is_read;
	logic [31:0] exp_host_rdata;
	int          pass_cnt;
	int          fail_cnt;

	byte         kinds [$];
	logic [31:0] field_a [$];
	logic [31:0] field_b [$];
	logic [31:0] field_c [$];
	logic [31:0] shadow [32]; // Register contents as the tests expect them.
	logic [31:0] rng_state;
	int          cycles = 0;
	int          limit = 0;
	int          expected_checks = 0;
	int          bad_lines = 0;

	mips_exec_top dut0 (
		.clk        (clk),
		.rst        (rst),
		.instr_req  (instr_req),
		.instr      (instr),
		.instr_ack  (instr_ack),
		.result     (result),
		.illegal    (illegal),
		.host_req   (host_req),
		.host_we    (host_we),
		.host_addr  (host_addr),
		.host_wdata (host_wdata),
		.host_ack   (host_ack),
		.host_rdata (host_rdata)
	);

	rf_checker chk0 (
		.clk            (clk),
		.rst            (rst),
		.instr_ack      (instr_ack),
		.result         (result),
		.illegal        (illegal),
		.host_ack       (host_ack),
		.host_rdata     (host_rdata),
		.exp_result     (exp_result),
		.exp_illegal    (exp_illegal),
		.host_is_read   (host_is_read),
		.exp_host_rdata (exp_host_rdata),
		.pass_cnt       (pass_cnt),
		.fail_cnt       (fail_cnt)
	);

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (limit > 0 && cycles >= limit) begin
			$display("Timeout after %0d cycles, a handshake never completed.", cycles);
			$display("Simulation finished: FAIL");
			$finish;
		end
	end

	function automatic logic [31:0] next_random();
		logic [31:0] x;
		x = rng_state;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		rng_state = x;
		return x;
	endfunction

	// *******************************************************************
	// Stimulus file and channel tasks
	// *******************************************************************

	task automatic read_tests();
		int          fd;
		int          n;
		string       line;
		byte         k;
		logic [31:0] a;
		logic [31:0] b;
		logic [31:0] c;
		fd = $fopen("verification/exec_input.txt", "r");
		if (fd == 0) begin
			$display("Cannot open verification/exec_input.txt.");
			bad_lines = bad_lines + 1;
		end else begin
			while (!$feof(fd)) begin
				line = "";
				void'($fgets(line, fd));
				if (line.len() > 0 && line[0] != "#") begin
					n = $sscanf(line, "%c %h %h %h", k, a, b, c);
					if (n == 4) begin
						kinds.push_back(k);
						field_a.push_back(a);
						field_b.push_back(b);
						field_c.push_back(c);
					end
				end
			end
			$fclose(fd);
		end
	endtask

	task automatic host_access(input logic we, input logic [4:0] addr,
			input logic [31:0] wdata, input logic [31:0] exp_rdata);
		@(posedge clk);
		host_is_read   <= !we;
		exp_host_rdata <= exp_rdata;
		host_we        <= we;
		host_addr      <= addr;
		host_wdata     <= wdata;
		host_req       <= 1'b1;
		do @(posedge clk); while (host_ack !== 1'b1);
		host_req <= 1'b0;
		do @(posedge clk); while (host_ack !== 1'b0);
	endtask

	// Runs one instruction, sometimes with a host read of another register beside it.
	task automatic run_instr(input logic [31:0] word, input logic [31:0] exp_res,
			input logic exp_ill);
		logic [4:0]  dest;
		logic [4:0]  side_addr;
		logic [31:0] rnd;
		logic        side_read;
		dest = (opcode_e'(word[31:26]) == OP_RTYPE) ? word[15:11] : word[20:16];
		rnd = next_random();
		side_read = (rnd[1:0] != 2'b00);
		side_addr = rnd[12:8];
		if (side_addr == dest) begin
			side_addr = side_addr + 5'd1;
		end
		@(posedge clk);
		exp_result  <= exp_res;
		exp_illegal <= exp_ill;
		instr       <= word;
		instr_req   <= 1'b1;
		fork
			begin
				do @(posedge clk); while (instr_ack !== 1'b1);
				instr_req <= 1'b0;
				do @(posedge clk); while (instr_ack !== 1'b0);
			end
			begin
				if (side_read) begin
					repeat (rnd[5:4]) @(posedge clk);
					host_access(1'b0, side_addr, 32'h0, shadow[side_addr]);
				end
			end
		join
		expected_checks = expected_checks + (side_read ? 2 : 1);
		if (!exp_ill && dest != ZERO) begin
			shadow[dest] = exp_res;
		end
	endtask

	// *******************************************************************
	// Test sequence
	// *******************************************************************

	initial begin
		rst            = 1'b0;
		instr_req      = 1'b0;
		instr          = '0;
		host_req       = 1'b0;
		host_we        = 1'b0;
		host_addr      = '0;
		host_wdata     = '0;
		exp_result     = '0;
		exp_illegal    = 1'b0;
		host_is_read   = 1'b0;
		exp_host_rdata = '0;
		rng_state      = 32'd9780;
		for (int r = 0; r < 32; r++) begin
			shadow[r] = '0;
		end
		read_tests();
		limit = kinds.size() * 40 + 100;
		repeat (4) @(posedge clk);
		rst <= 1'b1;
		for (int i = 0; i < kinds.size(); i++) begin
			repeat (next_random() % 4) @(posedge clk);
			case (kinds[i])
				"H": begin
					host_access(1'b1, field_a[i][4:0], field_b[i], 32'h0);
					if (field_a[i][4:0] != ZERO) begin
						shadow[field_a[i][4:0]] = field_b[i];
					end
				end
				"R": begin
					host_access(1'b0, field_a[i][4:0], 32'h0, field_b[i]);
					expected_checks = expected_checks + 1;
				end
				"I": run_instr(field_a[i], field_b[i], field_c[i][0]);
				default: begin
					$display("Test line %0d has an unknown kind and was not run.", i);
					bad_lines = bad_lines + 1;
				end
			endcase
		end
		repeat (2) @(posedge clk);
		$display("Checks: %0d passed, %0d failed, %0d expected", pass_cnt, fail_cnt,
			expected_checks);
		if (fail_cnt == 0 && bad_lines == 0 && kinds.size() > 0 &&
				pass_cnt == expected_checks) begin
			$display("Simulation finished: PASS");
		end else begin
			if (pass_cnt + fail_cnt != expected_checks) begin
				$display("Only %0d of %0d checks ran.", pass_cnt + fail_cnt, expected_checks);
			end
			$display("Simulation finished: FAIL");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- verification/exec_input.txt
# Columns in hex: kind a b c. H = host write (addr, data, 0), R = host read (addr, expected, 0),
# I = instruction (word, expected result, expected illegal flag). Lines starting with # are skipped.
H 08 00000015 0
H 09 FFFFFFF9 0
H 0A 0000F0F0 0
H 10 00000077 0
R 08 00000015 0
R 09 FFFFFFF9 0
H 00 DEADBEEF 0
R 00 00000000 0
I 010A5820 0000F105 0
R 0B 0000F105 0
I 01096022 0000001C 0
R 0C 0000001C 0
I 012A6824 0000F0F0 0
R 0D 0000F0F0 0
I 010A7025 0000F0F5 0
R 0E 0000F0F5 0
I 0128782A 00000001 0
R 0F 00000001 0
I 0109802A 00000000 0
R 10 00000000 0
I 2111FFFB 00000010 0
R 11 00000010 0
I 35128001 00008015 0
R 12 00008015 0
I FD0B1234 00000000 1
R 0B 0000F105 0
I 0109683F 00000000 1
R 0D 0000F0F0 0
I 010A0020 0000F105 0
R 00 00000000 0
I 21000001 00000016 0
R 00 00000000 0

//--- compile.f
src/mips_isa_pkg.sv
src/rf_bus_pkg.sv
src/rf_bus_if.sv
src/register_file.sv
src/rf_arbiter.sv
src/instr_executor.sv
src/host_reg_port.sv
src/mips_exec_top.sv
verification/rf_checker.sv
verification/tb_mips_exec.sv

//--- Bender.yml
package:
  name: mips_exec

sources:
  - src/mips_isa_pkg.sv
  - src/rf_bus_pkg.sv
  - src/rf_bus_if.sv
  - src/register_file.sv
  - src/rf_arbiter.sv
  - src/instr_executor.sv
  - src/host_reg_port.sv
  - src/mips_exec_top.sv
  - target: test
    files:
      - verification/rf_checker.sv
      - verification/tb_mips_exec.sv
